/* tb.f */
+incdir+design
design/rf_pkg.sv
design/wb_order_unit.sv
design/reg_array.sv
design/read_lane.sv
design/operand_pair_pack.sv
design/rf_subsystem.sv
testbench/rf_tb.sv

/* Makefile */
# Verilator flow for the register file subsystem

VERILATOR ?= verilator
TOP       ?= rf_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the exact pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/rf_tb.sv */
`timescale 1ns/1ps
`include "rf_cfg.svh"

module rf_tb;

    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 400;
    // Every phase plus the idle gaps between them
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 1
                                 + (`RF_REG_NUM / `RF_READ_PORTS) + 1
                                 + `RF_REG_NUM * 3 + 8 * 3 + 8 * 2
                                 + (1 << `RF_READ_PORTS) + RANDOM_CYCLES + 4;
    localparam int TIMEOUT_NS    = TOTAL_CYCLES * 10 + 500;

    logic clk = 1'b0;
    logic rst_n;
    rf_pkg::wb_slot_t [1:0]                wb_slot;
    rf_pkg::rd_req_t  [`RF_READ_PORTS-1:0] rd_req;
    rf_pkg::op_pair_t [`RF_PAIR_NUM-1:0]   pair;
    rf_pkg::op_pair_t [`RF_PAIR_NUM-1:0]   exp_pair;

    rf_pkg::xlen_t          model [`RF_REG_NUM];
    rf_pkg::wb_slot_t [1:0] wb_q;              // Writebacks held back one cycle
    int                     cur_test;
    int                     test_id;
    int                     test_id_q;
    logic [15:0]            lfsr_state;

    always #5 clk = ~clk;

    rf_subsystem dut_i (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .wb_slot_i (wb_slot),
        .rd_req_i  (rd_req),
        .pair_o    (pair)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic rf_pkg::wb_slot_t make_wb(logic v, rf_pkg::pc_t pc,
                                                 rf_pkg::reg_addr_t a, rf_pkg::xlen_t d);
        rf_pkg::wb_slot_t s;
        s.valid = v;
        s.pc    = pc;
        s.addr  = a;
        s.data  = d;
        return s;
    endfunction

    function automatic rf_pkg::rd_req_t make_req(logic v, rf_pkg::reg_addr_t a);
        rf_pkg::rd_req_t r;
        r.valid = v;
        r.addr  = a;
        return r;
    endfunction

    function automatic string test_label(int id);
        case (id)
            1:       return "reset_reads";
            2:       return "single_write";
            3:       return "same_reg_conflict";
            4:       return "write_bypass";
            5:       return "pair_valid";
            6:       return "random_mix";
            default: return "reset";
        endcase
    endfunction

    // x0 never changes
    function automatic void write_model(rf_pkg::wb_slot_t s);
        if (s.valid && s.addr != '0) begin
            model[s.addr] = s.data;
        end
    endfunction

    // Older first, so the younger value stays on a shared register
    function automatic void commit_writeback(rf_pkg::wb_slot_t s0, rf_pkg::wb_slot_t s1);
        if (s0.pc > s1.pc) begin
            write_model(s1);
            write_model(s0);
        end else begin
            write_model(s0);
            write_model(s1);
        end
    endfunction

    function automatic rf_pkg::op_pair_t expect_pair(int k);
        rf_pkg::op_pair_t p;
        rf_pkg::rd_req_t  a;
        rf_pkg::rd_req_t  b;
        a       = rd_req[2*k];
        b       = rd_req[2*k+1];
        p.valid = a.valid || b.valid;
        p.src1  = a.valid ? model[a.addr] : '0;   // Idle source reads as zero
        p.src2  = b.valid ? model[b.addr] : '0;
        return p;
    endfunction

    // Model state for the cycle that follows each edge
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RF_REG_NUM; i++) begin
                model[i] = '0;
            end
            wb_q      <= '0;
            exp_pair  <= '0;
            test_id_q <= 0;
        end else begin
            commit_writeback(wb_q[0], wb_q[1]);
            for (int k = 0; k < `RF_PAIR_NUM; k++) begin
                exp_pair[k] <= expect_pair(k);
            end
            wb_q      <= wb_slot;
            test_id_q <= test_id;
        end
    end

    task automatic report_mismatch(int id, int k, rf_pkg::op_pair_t exp,
                                   rf_pkg::op_pair_t act);
        // Fields shown as valid src1 src2
        $display("Error in %s, pair %0d: expected %b %h %h, actual %b %h %h",
                 test_label(id), k, exp.valid, exp.src1, exp.src2,
                 act.valid, act.src1, act.src2);
        $display("Regression failed");
        $fatal(1, "operand pair mismatch");
    endtask

    for (genvar k = 0; k < `RF_PAIR_NUM; k++) begin : g_check
        a_pair_match: assert property (@(posedge clk) disable iff (!rst_n)
            pair[k] == exp_pair[k])
            else report_mismatch($sampled(test_id_q), k, $sampled(exp_pair[k]),
                                 $sampled(pair[k]));
    end

    task automatic drive(input rf_pkg::wb_slot_t s0, input rf_pkg::wb_slot_t s1,
                         input rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs);
        @(posedge clk);
        wb_slot[0] <= s0;
        wb_slot[1] <= s1;
        rd_req     <= reqs;
        test_id    <= cur_test;
    endtask

    task automatic reset_reads_test();
        rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs;
        cur_test = 1;
        for (int c = 0; c < `RF_REG_NUM / `RF_READ_PORTS; c++) begin
            for (int l = 0; l < `RF_READ_PORTS; l++) begin
                reqs[l] = make_req(1'b1, rf_pkg::reg_addr_t'(c * `RF_READ_PORTS + l));
            end
            drive('0, '0, reqs);
        end
        drive('0, '0, '0);
    endtask

    task automatic single_write_test();
        rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs;
        rf_pkg::wb_slot_t                     s;
        cur_test = 2;
        for (int r = 0; r < `RF_REG_NUM; r++) begin
            s = make_wb(1'b1, rf_pkg::pc_t'(32'h100 + r * 4), rf_pkg::reg_addr_t'(r),
                        take_bits(32));
            if (r % 2 == 0) drive(s, '0, '0);    // Slots take turns
            else drive('0, s, '0);
            drive('0, '0, '0);
            reqs                   = '0;
            reqs[0]                = make_req(1'b1, rf_pkg::reg_addr_t'(r));
            reqs[`RF_READ_PORTS-1] = make_req(1'b1, rf_pkg::reg_addr_t'(r));
            drive('0, '0, reqs);
        end
    endtask

    task automatic same_reg_test();
        rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs;
        rf_pkg::reg_addr_t                    r;
        rf_pkg::pc_t                          pc0;
        rf_pkg::pc_t                          pc1;
        cur_test = 3;
        for (int i = 0; i < 8; i++) begin
            r = rf_pkg::reg_addr_t'(take_bits(5));
            if (r == '0) r = 1;
            pc0 = rf_pkg::pc_t'(32'h2000 + i * 8);
            pc1 = (i % 2 == 1) ? pc0 + 4 : pc0 - 4;   // Younger slot alternates
            drive(make_wb(1'b1, pc0, r, take_bits(32)),
                  make_wb(1'b1, pc1, r, take_bits(32)), '0);
            drive('0, '0, '0);
            reqs    = '0;
            reqs[1] = make_req(1'b1, r);
            reqs[2] = make_req(1'b1, r);
            drive('0, '0, reqs);
        end
    endtask

    task automatic bypass_test();
        rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs;
        rf_pkg::reg_addr_t                    r;
        cur_test = 4;
        for (int i = 0; i < 8; i++) begin
            r = rf_pkg::reg_addr_t'(take_bits(5));
            if (r == '0) r = 2;
            // Same cycle read sees the old value
            reqs    = '0;
            reqs[0] = make_req(1'b1, r);
            drive(make_wb(1'b1, rf_pkg::pc_t'(32'h3000 + i * 4), r, take_bits(32)), '0, reqs);
            reqs    = '0;
            reqs[1] = make_req(1'b1, r);
            reqs[2] = make_req(1'b1, r);
            drive('0, '0, reqs);
        end
    endtask

    task automatic pair_valid_test();
        rf_pkg::rd_req_t [`RF_READ_PORTS-1:0] reqs;
        cur_test = 5;
        for (int m = 0; m < (1 << `RF_READ_PORTS); m++) begin
            for (int l = 0; l < `RF_READ_PORTS; l++) begin
                reqs[l] = make_req(m[l], rf_pkg::reg_addr_t'(take_bits(5)));
            end
            drive('0, '0, reqs);
        end
    endtask

    task automatic random_mix_test();
        rf_pkg::rd_req_t  [`RF_READ_PORTS-1:0] reqs;
        rf_pkg::wb_slot_t [1:0]                s;
        cur_test = 6;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            // Narrow write addresses so conflicts show up often
            for (int i = 0; i < 2; i++) begin
                s[i] = make_wb(1'(take_bits(1)), take_bits(32),
                               rf_pkg::reg_addr_t'(take_bits(4)), take_bits(32));
            end
            if (s[0].pc == s[1].pc) s[1].pc = s[1].pc ^ rf_pkg::pc_t'(1);
            for (int l = 0; l < `RF_READ_PORTS; l++) begin
                reqs[l] = make_req(1'(take_bits(1)), rf_pkg::reg_addr_t'(take_bits(4)));
            end
            drive(s[0], s[1], reqs);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        wb_slot    = '0;
        rd_req     = '0;
        cur_test   = 0;
        test_id    = 0;
        lfsr_state = 16'd87;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        drive('0, '0, '0);

        reset_reads_test();
        single_write_test();
        same_reg_test();
        bypass_test();
        pair_valid_test();
        random_mix_test();

        repeat (3) drive('0, '0, '0);   // Drain the last responses
        @(negedge clk);
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("Regression failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* design/rf_subsystem.sv */
`timescale 1ns/1ps
`include "rf_cfg.svh"

module rf_subsystem (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  rf_pkg::wb_slot_t [1:0]                   wb_slot_i,
    input  rf_pkg::rd_req_t  [`RF_READ_PORTS-1:0]    rd_req_i,
    output rf_pkg::op_pair_t [`RF_PAIR_NUM-1:0]      pair_o
);

    rf_pkg::wr_cmd_t   [1:0]                 wr_cmd;
    rf_pkg::reg_addr_t [`RF_READ_PORTS-1:0]  rd_addr;
    rf_pkg::xlen_t     [`RF_READ_PORTS-1:0]  raw_data;
    rf_pkg::rd_rsp_t   [`RF_READ_PORTS-1:0]  lane_rsp;

    // Slot in cycle N turns into a write command in N+1
    wb_order_unit u_wb_order (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_slot_i (wb_slot_i),
        .wr_cmd_o  (wr_cmd)
    );

    reg_array u_reg_array (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_cmd_i  (wr_cmd),
        .rd_addr_i (rd_addr),
        .rd_data_o (raw_data)
    );

    // One lane per source operand
    for (genvar i = 0; i < `RF_READ_PORTS; i++) begin : g_lane
        assign rd_addr[i] = rd_req_i[i].addr;

        read_lane u_lane (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .rd_req_i   (rd_req_i[i]),
            .raw_data_i (raw_data[i]),
            .wr_cmd_i   (wr_cmd),
            .rd_rsp_o   (lane_rsp[i])
        );
    end

    operand_pair_pack u_pair_pack (
        .rsp_i  (lane_rsp),
        .pair_o (pair_o)
    );

endmodule

/* design/operand_pair_pack.sv */
`timescale 1ns/1ps
`include "rf_cfg.svh"

module operand_pair_pack (
    input  rf_pkg::rd_rsp_t  [`RF_READ_PORTS-1:0] rsp_i,
    output rf_pkg::op_pair_t [`RF_PAIR_NUM-1:0]   pair_o
);

    // Lane 2k feeds src1, lane 2k+1 feeds src2
    always_comb begin
        for (int k = 0; k < `RF_PAIR_NUM; k++) begin
            pair_o[k].valid = rsp_i[2*k].valid || rsp_i[2*k+1].valid;

            // Idle lane shows up as a zero operand
            if (rsp_i[2*k].valid) begin
                pair_o[k].src1 = rsp_i[2*k].data;
            end else begin
                pair_o[k].src1 = '0;
            end

            if (rsp_i[2*k+1].valid) begin
                pair_o[k].src2 = rsp_i[2*k+1].data;
            end else begin
                pair_o[k].src2 = '0;
            end
        end
    end

endmodule

/* design/read_lane.sv */
`timescale 1ns/1ps

module read_lane (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rf_pkg::rd_req_t         rd_req_i,
    input  rf_pkg::xlen_t           raw_data_i,
    input  rf_pkg::wr_cmd_t [1:0]   wr_cmd_i,
    output rf_pkg::rd_rsp_t         rd_rsp_o
);

    rf_pkg::xlen_t   fwd_data;
    rf_pkg::rd_rsp_t rsp_q;
    logic            hit0;
    logic            hit1;

    // Writes still in flight this cycle
    assign hit0 = wr_cmd_i[0].en && (wr_cmd_i[0].addr == rd_req_i.addr);
    assign hit1 = wr_cmd_i[1].en && (wr_cmd_i[1].addr == rd_req_i.addr);

    always_comb begin
        if (hit1) begin
            fwd_data = wr_cmd_i[1].data;  // Command 1 has priority
        end else if (hit0) begin
            fwd_data = wr_cmd_i[0].data;
        end else begin
            fwd_data = raw_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_q.valid <= 1'b0;
        end else begin
            rsp_q.valid <= rd_req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_q.data <= rd_req_i.valid ? fwd_data : '0;
    end

    assign rd_rsp_o = rsp_q;

endmodule

/* design/reg_array.sv */
`timescale 1ns/1ps
`include "rf_cfg.svh"

module reg_array (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    input  rf_pkg::wr_cmd_t   [1:0]                     wr_cmd_i,
    input  rf_pkg::reg_addr_t [`RF_READ_PORTS-1:0]      rd_addr_i,
    output rf_pkg::xlen_t     [`RF_READ_PORTS-1:0]      rd_data_o
);

    rf_pkg::xlen_t regs [`RF_REG_NUM];

    // Writes land at the end of the command cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RF_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_cmd_i[0].en) begin
                regs[wr_cmd_i[0].addr] <= wr_cmd_i[0].data;
            end
            if (wr_cmd_i[1].en) begin
                regs[wr_cmd_i[1].addr] <= wr_cmd_i[1].data;  // Port 1 last
            end
        end
    end

    // Raw reads, bypass is handled per lane
    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            rd_data_o[i] = regs[rd_addr_i[i]];
        end
    end

endmodule

/* design/wb_order_unit.sv */
`timescale 1ns/1ps
`include "rf_cfg.svh"

module wb_order_unit (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  rf_pkg::wb_slot_t [1:0]     wb_slot_i,
    output rf_pkg::wr_cmd_t  [1:0]     wr_cmd_o
);

    rf_pkg::wb_slot_t [1:0] slot_q;
    logic                   same_reg;
    logic                   slot0_younger;

    // Valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot_q[0].valid <= 1'b0;
            slot_q[1].valid <= 1'b0;
        end else begin
            slot_q[0].valid <= wb_slot_i[0].valid;
            slot_q[1].valid <= wb_slot_i[1].valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            slot_q[i].pc   <= wb_slot_i[i].pc;
            slot_q[i].addr <= wb_slot_i[i].addr;
            slot_q[i].data <= wb_slot_i[i].data;
        end
    end

    assign same_reg      = slot_q[0].valid && slot_q[1].valid &&
                           (slot_q[0].addr == slot_q[1].addr);
    assign slot0_younger = slot_q[0].pc > slot_q[1].pc;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_cmd_o[i].addr = slot_q[i].addr;
            wr_cmd_o[i].data = slot_q[i].data;
        end

        if (same_reg) begin
            // Younger instruction owns the final value
            wr_cmd_o[0].en = slot0_younger;
            wr_cmd_o[1].en = !slot0_younger;
        end else begin
            wr_cmd_o[0].en = slot_q[0].valid;
            wr_cmd_o[1].en = slot_q[1].valid;
        end

        // x0 is hardwired, drop anything aimed at it
        if (slot_q[0].addr == '0) wr_cmd_o[0].en = 1'b0;
        if (slot_q[1].addr == '0) wr_cmd_o[1].en = 1'b0;
    end

endmodule

/* design/rf_pkg.sv */
`include "rf_cfg.svh"

package rf_pkg;

    typedef logic [`RF_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RF_XLEN-1:0]   xlen_t;
    typedef logic [`RF_PC_W-1:0]   pc_t;

    // One writeback from a pipeline slot
    typedef struct packed {
        logic      valid;
        pc_t       pc;      // Orders the two slots
        reg_addr_t addr;
        xlen_t     data;
    } wb_slot_t;

    // Resolved write, en never set for x0
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
    } wr_cmd_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        xlen_t data;
    } rd_rsp_t;

    // Source operands of one instruction
    typedef struct packed {
        logic  valid;
        xlen_t src1;
        xlen_t src2;
    } op_pair_t;

endpackage

/* design/rf_cfg.svh */
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// Register file geometry

// Architectural integer registers
`define RF_REG_NUM 32

// Bits needed to name one register
`define RF_ADDR_W 5

// Data word width
`define RF_XLEN 32

// Instruction address width, used to age writebacks
`define RF_PC_W 32

// Operand read lanes, two per issued instruction
// Must stay even since lanes are grouped in pairs
`define RF_READ_PORTS 4

// Number of source pairs handed to issue
`define RF_PAIR_NUM (`RF_READ_PORTS / 2)

`endif
